/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_mem
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' list.f)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "Finished with errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qx "Finished with no errors" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
verilog/axi_mem_pkg.sv
verilog/rsp_fifo.sv
verilog/axi_to_mem_adapter.sv
verilog/mem_bank.sv
verilog/axi_mem_top.sv
tb/axi_mem_assert.sv
tb/tb_axi_mem.sv

/* tb/axi_mem_assert.sv */
//////////////////////////////
// protocol checks bound into
// the axi to memory adapter
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_mem_assert (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input axi_mem_pkg::axi_req_t axi_req_i,
    input axi_mem_pkg::axi_rsp_t axi_rsp_i,
    input logic                  r_push_i,
    input logic                  b_push_i,
    input axi_mem_pkg::cnt_t     r_free_i,
    input axi_mem_pkg::cnt_t     b_free_i,
    input axi_mem_pkg::cnt_t     r_cnt_i,
    input axi_mem_pkg::cnt_t     b_cnt_i
);

    r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axi_rsp_i.r_valid && !axi_req_i.r_ready |=> axi_rsp_i.r_valid && $stable(axi_rsp_i.r))
        else $error("r channel changed while stalled");

    b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axi_rsp_i.b_valid && !axi_req_i.b_ready |=> axi_rsp_i.b_valid && $stable(axi_rsp_i.b))
        else $error("b channel changed while stalled");

    // every response needs a request still in flight.
    r_one_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i) r_push_i |-> r_cnt_i != '0)
        else $error("read response without a pending request");

    b_one_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i) b_push_i |-> b_cnt_i != '0)
        else $error("write response without a pending request");

    r_no_ovf: assert property (@(posedge clk_i) disable iff (!rst_n_i) r_push_i |-> r_free_i != '0)
        else $error("r fifo pushed while full");

    b_no_ovf: assert property (@(posedge clk_i) disable iff (!rst_n_i) b_push_i |-> b_free_i != '0)
        else $error("b fifo pushed while full");

endmodule

bind axi_to_mem_adapter axi_mem_assert u_assert (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .axi_req_i(axi_req_i),
    .axi_rsp_i(axi_rsp_o),
    .r_push_i (r_push),
    .b_push_i (b_push),
    .r_free_i (r_free),
    .b_free_i (b_free),
    .r_cnt_i  (r_cnt_q),
    .b_cnt_i  (b_cnt_q)
);

`default_nettype wire

/* tb/axi_mem_golden.txt */
# phase op(R/W) id addr wdata strb resp rdata, all but phase in hex
# resp 0 is okay, 2 is slverr; rdata is checked on reads only
1 W 1 000 00000000 f 0 00000000
1 W 2 000 0000beef 3 0 00000000
1 W 3 004 11223344 f 0 00000000
1 W 4 004 aa000000 8 0 00000000
1 W 5 008 00000000 f 0 00000000
1 W 6 008 00cd0000 4 0 00000000
1 W 7 3fc 12345678 f 0 00000000
1 W 8 400 deadbeef f 2 00000000
1 W 9 ffc cafef00d f 2 00000000
2 R 1 000 00000000 0 0 0000beef
2 R 2 004 00000000 0 0 aa223344
2 R 3 008 00000000 0 0 00cd0000
2 R 4 400 00000000 0 2 00000000
2 R 5 ffc 00000000 0 2 00000000
2 R 6 3fc 00000000 0 0 12345678
3 W a 100 01020304 f 0 00000000
3 R 7 000 00000000 0 0 0000beef
3 W b 104 a0b0c0d0 f 0 00000000
3 R 8 004 00000000 0 0 aa223344
3 W c 108 ffffffff f 0 00000000
3 R 9 008 00000000 0 0 00cd0000
3 W d 10c 0badf00d f 0 00000000
3 R a 3fc 00000000 0 0 12345678
4 R b 100 00000000 0 0 01020304
4 R c 10c 00000000 0 0 0badf00d

/* tb/tb_axi_mem.sv */
//////////////////////////////
// testbench for the axi memory
// top, driven by the golden file
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem;

    localparam int ClkPeriod = 40;
    localparam int MaxOps    = 64;

    logic                  clk = 1'b0;
    logic                  rst_n;
    axi_mem_pkg::axi_req_t axi_req;
    axi_mem_pkg::axi_rsp_t axi_rsp;

    logic                  ar_valid;
    axi_mem_pkg::ar_chan_t ar;
    logic                  aw_valid;
    axi_mem_pkg::aw_chan_t aw;
    logic                  w_valid;
    axi_mem_pkg::w_chan_t  w;
    logic                  r_ready = 1'b0;
    logic                  b_ready = 1'b0;

    // one entry per golden line.
    int                    phase_a   [MaxOps];
    bit                    is_read_a [MaxOps];
    axi_mem_pkg::id_t      id_a      [MaxOps];
    axi_mem_pkg::addr_t    addr_a    [MaxOps];
    axi_mem_pkg::data_t    wdata_a   [MaxOps];
    axi_mem_pkg::strb_t    strb_a    [MaxOps];
    axi_mem_pkg::resp_t    resp_a    [MaxOps];
    axi_mem_pkg::data_t    rdata_a   [MaxOps];

    int                    n_ops        = 0;
    int                    last_phase   = 0;
    bit                    loaded       = 1'b0;
    int                    r_exp [$];   // golden indices in issue order.
    int                    b_exp [$];
    bit                    both_seen    = 1'b0;
    int                    mismatch_cnt = 0;
    int                    other_cnt    = 0;
    int                    seed         = 32'hc936_81f0;

    axi_mem_top u_dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .axi_req_i(axi_req),
        .axi_rsp_o(axi_rsp)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    always_comb begin
        axi_req.aw_valid = aw_valid;
        axi_req.aw       = aw;
        axi_req.w_valid  = w_valid;
        axi_req.w        = w;
        axi_req.b_ready  = b_ready;
        axi_req.ar_valid = ar_valid;
        axi_req.ar       = ar;
        axi_req.r_ready  = r_ready;
    end

    // random back-pressure, high about three cycles in four.
    always @(posedge clk) begin
        logic [31:0] rnd;
        #1;
        rnd     = $random(seed);
        r_ready = rnd[0] | rnd[1];
        b_ready = rnd[2] | rnd[3];
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_cnt++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_idle();
        compare_field("r_valid", 32'(axi_rsp.r_valid), 32'd0);
        compare_field("b_valid", 32'(axi_rsp.b_valid), 32'd0);
        compare_field("aw_ready", 32'(axi_rsp.aw_ready), 32'd0);
        compare_field("w_ready", 32'(axi_rsp.w_ready), 32'd0);
        compare_field("ar_ready", 32'(axi_rsp.ar_ready), 32'd0);
    endtask

    task automatic load_golden();
        int                fd;
        int                cnt;
        int                ph;
        logic [8*160-1:0]  line;
        logic [7:0]        op_c;
        logic [31:0]       id_v;
        logic [31:0]       addr_v;
        logic [31:0]       wd_v;
        logic [31:0]       st_v;
        logic [31:0]       rs_v;
        logic [31:0]       rd_v;
        fd = $fopen("tb/axi_mem_golden.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("cannot open the golden file tb/axi_mem_golden.txt");
            return;
        end
        while (!$feof(fd) && n_ops < MaxOps) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%d %c %h %h %h %h %h %h",
                              ph, op_c, id_v, addr_v, wd_v, st_v, rs_v, rd_v);
                if (cnt == 8) begin  // comment and blank lines do not parse.
                    phase_a[n_ops]   = ph;
                    is_read_a[n_ops] = (op_c == "R");
                    id_a[n_ops]      = axi_mem_pkg::id_t'(id_v);
                    addr_a[n_ops]    = axi_mem_pkg::addr_t'(addr_v);
                    wdata_a[n_ops]   = wd_v;
                    strb_a[n_ops]    = axi_mem_pkg::strb_t'(st_v);
                    resp_a[n_ops]    = axi_mem_pkg::resp_t'(rs_v);
                    rdata_a[n_ops]   = rd_v;
                    if (ph > last_phase) last_phase = ph;
                    n_ops++;
                end
            end
        end
        $fclose(fd);
        if (n_ops == 0) begin
            other_cnt++;
            $display("the golden file holds no operations");
        end
    endtask

    task automatic issue_reads(input int ph);
        for (int i = 0; i < n_ops; i++) begin
            if (phase_a[i] == ph && is_read_a[i]) begin
                ar_valid = 1'b1;
                ar.addr  = addr_a[i];
                ar.id    = id_a[i];
                do @(negedge clk); while (!axi_rsp.ar_ready);
                r_exp.push_back(i);
                @(posedge clk);
                #1;
            end
        end
        ar_valid = 1'b0;
    endtask

    task automatic issue_writes(input int ph);
        for (int i = 0; i < n_ops; i++) begin
            if (phase_a[i] == ph && !is_read_a[i]) begin
                aw_valid = 1'b1;
                w_valid  = 1'b1;
                aw.addr  = addr_a[i];
                aw.id    = id_a[i];
                w.data   = wdata_a[i];
                w.strb   = strb_a[i];
                do @(negedge clk); while (!(axi_rsp.aw_ready && axi_rsp.w_ready));
                b_exp.push_back(i);
                @(posedge clk);
                #1;
            end
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
    endtask

    task automatic check_r();
        int idx;
        assert (r_exp.size() != 0) else begin
            other_cnt++;
            $display("R response arrived with no read outstanding");
        end
        if (r_exp.size() != 0) begin
            idx = r_exp.pop_front();
            compare_field("r.id", 32'(axi_rsp.r.id), 32'(id_a[idx]));
            compare_field("r.resp", 32'(axi_rsp.r.resp), 32'(resp_a[idx]));
            compare_field("r.data", axi_rsp.r.data, rdata_a[idx]);
        end
    endtask

    task automatic check_b();
        int idx;
        assert (b_exp.size() != 0) else begin
            other_cnt++;
            $display("B response arrived with no write outstanding");
        end
        if (b_exp.size() != 0) begin
            idx = b_exp.pop_front();
            compare_field("b.id", 32'(axi_rsp.b.id), 32'(id_a[idx]));
            compare_field("b.resp", 32'(axi_rsp.b.resp), 32'(resp_a[idx]));
        end
    endtask

    // handshakes complete on the next rising edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (axi_rsp.r_valid && r_ready) check_r();
            if (axi_rsp.b_valid && b_ready) check_b();
            if (ar_valid && axi_rsp.ar_ready && aw_valid && w_valid && axi_rsp.aw_ready) begin
                both_seen = 1'b1;
            end
        end
    end

    task automatic close_run();
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        wait (loaded);
        #((n_ops * 20 + 50) * ClkPeriod);
        other_cnt++;
        $display("timeout, responses still missing after %0d cycles", n_ops * 20 + 50);
        close_run();
    end

    initial begin
        rst_n    = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        load_golden();
        loaded = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();  // readies stay low one more cycle.
        for (int ph = 1; ph <= last_phase; ph++) begin
            @(posedge clk);
            #1;
            fork
                issue_reads(ph);
                issue_writes(ph);
            join
            while (r_exp.size() != 0 || b_exp.size() != 0) @(posedge clk);
        end
        assert (both_seen) else begin
            other_cnt++;
            $display("no cycle had read and write handshakes together");
        end
        close_run();
    end

endmodule

`default_nettype wire

/* verilog/axi_mem_pkg.sv */
//////////////////////////////
// widths, memory size and the
// packed axi and memory structs
//////////////////////////////
`default_nettype none

package axi_mem_pkg;

    localparam int unsigned AddrWidth = 12;  // byte address.
    localparam int unsigned DataWidth = 32;
    localparam int unsigned StrbWidth = DataWidth / 8;
    localparam int unsigned IdWidth   = 4;
    localparam int unsigned MemWords  = 256;
    localparam int unsigned BufDepth  = 2;

    localparam int unsigned WordIdxWidth = $clog2(MemWords);
    localparam int unsigned CntWidth     = $clog2(BufDepth + 1);
    localparam int unsigned BufPtrWidth  = (BufDepth > 1) ? $clog2(BufDepth) : 1;

    typedef logic [AddrWidth-1:0]    addr_t;
    typedef logic [DataWidth-1:0]    data_t;
    typedef logic [StrbWidth-1:0]    strb_t;
    typedef logic [IdWidth-1:0]      id_t;
    typedef logic [1:0]              resp_t;
    typedef logic [WordIdxWidth-1:0] word_idx_t;
    typedef logic [CntWidth-1:0]     cnt_t;
    typedef logic [BufPtrWidth-1:0]  buf_ptr_t;

    localparam resp_t RespOkay   = 2'd0;
    localparam resp_t RespSlvErr = 2'd2;

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } ar_chan_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
    } r_chan_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_chan_t;

    // manager side of the port.
    typedef struct packed {
        logic     aw_valid;
        aw_chan_t aw;
        logic     w_valid;
        w_chan_t  w;
        logic     b_ready;
        logic     ar_valid;
        ar_chan_t ar;
        logic     r_ready;
    } axi_req_t;

    typedef struct packed {
        logic    aw_ready;
        logic    w_ready;
        logic    b_valid;
        b_chan_t b;
        logic    ar_ready;
        logic    r_valid;
        r_chan_t r;
    } axi_rsp_t;

    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
        logic  write;
    } mem_q_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        logic  err;   // address out of range.
    } mem_p_t;

    typedef struct packed {
        logic   q_valid;
        mem_q_t q;
    } mem_req_t;

    typedef struct packed {
        logic   q_ready;
        mem_p_t p;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* verilog/axi_mem_top.sv */
//////////////////////////////
// adapter on split ports and
// a two-port bank
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  axi_mem_pkg::axi_req_t axi_req_i,
    output axi_mem_pkg::axi_rsp_t axi_rsp_o
);

    axi_mem_pkg::mem_req_t [1:0] mem_req;  // 0 reads, 1 writes.
    axi_mem_pkg::mem_rsp_t [1:0] mem_rsp;

    axi_to_mem_adapter #(
        .ReadWrite(1'b1),
        .axi_req_t(axi_mem_pkg::axi_req_t),
        .axi_rsp_t(axi_mem_pkg::axi_rsp_t),
        .mem_req_t(axi_mem_pkg::mem_req_t),
        .mem_rsp_t(axi_mem_pkg::mem_rsp_t)
    ) i_adapter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .axi_req_i(axi_req_i),
        .axi_rsp_o(axi_rsp_o),
        .mem_req_o(mem_req),
        .mem_rsp_i(mem_rsp)
    );

    mem_bank #(
        .NumPorts(2)
    ) i_bank (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .mem_req_i(mem_req),
        .mem_rsp_o(mem_rsp)
    );

endmodule

`default_nettype wire

/* verilog/axi_to_mem_adapter.sv */
//////////////////////////////
// axi single-beat port to memory
// requests, split or shared port
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axi_to_mem_adapter #(
    parameter bit  ReadWrite = 1'b1,
    parameter type axi_req_t = axi_mem_pkg::axi_req_t,
    parameter type axi_rsp_t = axi_mem_pkg::axi_rsp_t,
    parameter type mem_req_t = axi_mem_pkg::mem_req_t,
    parameter type mem_rsp_t = axi_mem_pkg::mem_rsp_t
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  axi_req_t               axi_req_i,
    output axi_rsp_t               axi_rsp_o,
    output mem_req_t [ReadWrite:0] mem_req_o,
    input  mem_rsp_t [ReadWrite:0] mem_rsp_i
);

    logic                  rdy_en_q;   // holds readies low for one cycle out of reset.
    logic                  wr_pend;
    logic                  ar_ready;
    logic                  wr_ready;
    logic                  ar_hs;
    logic                  wr_hs;
    logic                  r_push;
    logic                  b_push;
    logic                  r_pop;
    logic                  b_pop;
    logic                  r_valid;
    logic                  b_valid;
    logic                  r_credit;
    logic                  b_credit;
    axi_mem_pkg::r_chan_t  r_in;
    axi_mem_pkg::r_chan_t  r_out;
    axi_mem_pkg::b_chan_t  b_in;
    axi_mem_pkg::b_chan_t  b_out;
    axi_mem_pkg::cnt_t     r_free;
    axi_mem_pkg::cnt_t     b_free;
    axi_mem_pkg::cnt_t     r_cnt_q;    // requests still waiting for p.valid.
    axi_mem_pkg::cnt_t     b_cnt_q;

    assign wr_pend  = axi_req_i.aw_valid && axi_req_i.w_valid;
    assign r_credit = r_free > r_cnt_q;
    assign b_credit = b_free > b_cnt_q;
    assign ar_hs    = axi_req_i.ar_valid && ar_ready;
    assign wr_hs    = wr_pend && wr_ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rdy_en_q <= 1'b0;
            r_cnt_q  <= '0;
            b_cnt_q  <= '0;
        end else begin
            rdy_en_q <= 1'b1;
            r_cnt_q  <= r_cnt_q + axi_mem_pkg::cnt_t'(ar_hs) - axi_mem_pkg::cnt_t'(r_push);
            b_cnt_q  <= b_cnt_q + axi_mem_pkg::cnt_t'(wr_hs) - axi_mem_pkg::cnt_t'(b_push);
        end
    end

    if (ReadWrite) begin : gen_split
        // port 0 serves reads, port 1 serves writes.
        axi_mem_pkg::id_t r_id_q;
        axi_mem_pkg::id_t b_id_q;

        assign ar_ready = rdy_en_q && r_credit && mem_rsp_i[0].q_ready;
        assign wr_ready = rdy_en_q && b_credit && mem_rsp_i[1].q_ready && wr_pend;

        assign mem_req_o[0].q_valid = rdy_en_q && r_credit && axi_req_i.ar_valid;
        assign mem_req_o[0].q.addr  = axi_req_i.ar.addr;
        assign mem_req_o[0].q.data  = '0;
        assign mem_req_o[0].q.strb  = '0;
        assign mem_req_o[0].q.write = 1'b0;

        assign mem_req_o[1].q_valid = rdy_en_q && b_credit && wr_pend;
        assign mem_req_o[1].q.addr  = axi_req_i.aw.addr;
        assign mem_req_o[1].q.data  = axi_req_i.w.data;
        assign mem_req_o[1].q.strb  = axi_req_i.w.strb;
        assign mem_req_o[1].q.write = 1'b1;

        // the bank answers after one cycle, so one id per port is enough.
        always_ff @(posedge clk_i) begin
            if (ar_hs) r_id_q <= axi_req_i.ar.id;
            if (wr_hs) b_id_q <= axi_req_i.aw.id;
        end

        assign r_push    = mem_rsp_i[0].p.valid;
        assign r_in.id   = r_id_q;
        assign r_in.data = mem_rsp_i[0].p.data;
        assign r_in.resp = mem_rsp_i[0].p.err ? axi_mem_pkg::RespSlvErr : axi_mem_pkg::RespOkay;

        assign b_push    = mem_rsp_i[1].p.valid;
        assign b_in.id   = b_id_q;
        assign b_in.resp = mem_rsp_i[1].p.err ? axi_mem_pkg::RespSlvErr : axi_mem_pkg::RespOkay;
    end else begin : gen_shared
        typedef struct packed {
            logic             write;
            axi_mem_pkg::id_t id;
        } tag_t;

        logic              wr_go;
        logic              rd_go;
        logic              tag_room;
        logic              tag_valid;
        tag_t              tag_in;
        tag_t              tag_head;
        axi_mem_pkg::cnt_t tag_free;

        assign tag_room = (tag_free != '0);
        assign wr_go    = rdy_en_q && wr_pend && b_credit && tag_room;  // writes first.
        assign rd_go    = rdy_en_q && axi_req_i.ar_valid && r_credit && tag_room && !wr_go;
        assign wr_ready = wr_go && mem_rsp_i[0].q_ready;
        assign ar_ready = rd_go && mem_rsp_i[0].q_ready;

        assign mem_req_o[0].q_valid = wr_go || rd_go;
        assign mem_req_o[0].q.addr  = wr_go ? axi_req_i.aw.addr : axi_req_i.ar.addr;
        assign mem_req_o[0].q.data  = axi_req_i.w.data;
        assign mem_req_o[0].q.strb  = wr_go ? axi_req_i.w.strb : '0;
        assign mem_req_o[0].q.write = wr_go;

        assign tag_in.write = wr_go;
        assign tag_in.id    = wr_go ? axi_req_i.aw.id : axi_req_i.ar.id;

        // order of accepted requests, one entry per request in flight.
        rsp_fifo #(
            .payload_t(tag_t)
        ) i_tag_fifo (
            .clk_i  (clk_i),
            .rst_n_i(rst_n_i),
            .push_i (ar_hs || wr_hs),
            .data_i (tag_in),
            .pop_i  (mem_rsp_i[0].p.valid),
            .data_o (tag_head),
            .valid_o(tag_valid),
            .free_o (tag_free)
        );

        assign r_push    = mem_rsp_i[0].p.valid && tag_valid && !tag_head.write;
        assign b_push    = mem_rsp_i[0].p.valid && tag_valid && tag_head.write;
        assign r_in.id   = tag_head.id;
        assign r_in.data = mem_rsp_i[0].p.data;
        assign r_in.resp = mem_rsp_i[0].p.err ? axi_mem_pkg::RespSlvErr : axi_mem_pkg::RespOkay;
        assign b_in.id   = tag_head.id;
        assign b_in.resp = r_in.resp;
    end

    assign r_pop = r_valid && axi_req_i.r_ready;
    assign b_pop = b_valid && axi_req_i.b_ready;

    rsp_fifo #(
        .payload_t(axi_mem_pkg::r_chan_t)
    ) i_r_fifo (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .push_i (r_push),
        .data_i (r_in),
        .pop_i  (r_pop),
        .data_o (r_out),
        .valid_o(r_valid),
        .free_o (r_free)
    );

    rsp_fifo #(
        .payload_t(axi_mem_pkg::b_chan_t)
    ) i_b_fifo (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .push_i (b_push),
        .data_i (b_in),
        .pop_i  (b_pop),
        .data_o (b_out),
        .valid_o(b_valid),
        .free_o (b_free)
    );

    assign axi_rsp_o.aw_ready = wr_ready;
    assign axi_rsp_o.w_ready  = wr_ready;  // aw and w are taken together.
    assign axi_rsp_o.b_valid  = b_valid;
    assign axi_rsp_o.b        = b_out;
    assign axi_rsp_o.ar_ready = ar_ready;
    assign axi_rsp_o.r_valid  = r_valid;
    assign axi_rsp_o.r        = r_out;

endmodule

`default_nettype wire

/* verilog/mem_bank.sv */
//////////////////////////////
// sram bank with byte strobes
// and one-cycle responses
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
    parameter int NumPorts = 2
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  axi_mem_pkg::mem_req_t [NumPorts-1:0] mem_req_i,
    output axi_mem_pkg::mem_rsp_t [NumPorts-1:0] mem_rsp_o
);

    axi_mem_pkg::data_t mem_q [axi_mem_pkg::MemWords];

    function automatic logic in_range(axi_mem_pkg::addr_t addr);
        return 32'(addr) < axi_mem_pkg::MemWords * 4;
    endfunction

    function automatic axi_mem_pkg::word_idx_t word_idx(axi_mem_pkg::addr_t addr);
        return addr[axi_mem_pkg::WordIdxWidth+1:2];
    endfunction

    // strobed writes. a higher port wins a same-word collision.
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NumPorts; p++) begin
            if (mem_req_i[p].q_valid && mem_req_i[p].q.write && in_range(mem_req_i[p].q.addr)) begin
                for (int b = 0; b < axi_mem_pkg::StrbWidth; b++) begin
                    if (mem_req_i[p].q.strb[b]) begin
                        mem_q[word_idx(mem_req_i[p].q.addr)][8*b +: 8] <=
                            mem_req_i[p].q.data[8*b +: 8];
                    end
                end
            end
        end
    end

    for (genvar p = 0; p < NumPorts; p++) begin : gen_port
        logic               hit;
        logic               valid_q;
        logic               err_q;
        axi_mem_pkg::data_t data_q;

        assign hit = in_range(mem_req_i[p].q.addr);

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= mem_req_i[p].q_valid;  // q_ready is always high.
            end
        end

        // reads see the word as it was before this edge.
        always_ff @(posedge clk_i) begin
            if (mem_req_i[p].q_valid) begin
                err_q  <= !hit;
                data_q <= (hit && !mem_req_i[p].q.write) ?
                          mem_q[word_idx(mem_req_i[p].q.addr)] : '0;
            end
        end

        assign mem_rsp_o[p].q_ready = 1'b1;
        assign mem_rsp_o[p].p.valid = valid_q;
        assign mem_rsp_o[p].p.data  = data_q;
        assign mem_rsp_o[p].p.err   = err_q;
    end

endmodule

`default_nettype wire

/* verilog/rsp_fifo.sv */
//////////////////////////////
// small synchronous fifo with
// a typed payload and free count
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rsp_fifo #(
    parameter type payload_t = logic
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              push_i,
    input  payload_t          data_i,
    input  logic              pop_i,
    output payload_t          data_o,
    output logic              valid_o,
    output axi_mem_pkg::cnt_t free_o
);

    payload_t                buf_q [axi_mem_pkg::BufDepth];
    axi_mem_pkg::buf_ptr_t   wr_ptr_q;
    axi_mem_pkg::buf_ptr_t   rd_ptr_q;
    axi_mem_pkg::cnt_t       count_q;
    logic                    do_push;
    logic                    do_pop;

    function automatic axi_mem_pkg::buf_ptr_t ptr_next(axi_mem_pkg::buf_ptr_t ptr);
        if (ptr == axi_mem_pkg::buf_ptr_t'(axi_mem_pkg::BufDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign valid_o = (count_q != '0);
    assign free_o  = axi_mem_pkg::cnt_t'(axi_mem_pkg::BufDepth) - count_q;
    assign do_push = push_i && (free_o != '0);  // a push into a full buffer is lost.
    assign do_pop  = pop_i && valid_o;
    assign data_o  = buf_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_next(rd_ptr_q);
            count_q <= count_q + axi_mem_pkg::cnt_t'(do_push) - axi_mem_pkg::cnt_t'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            buf_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire
